/* rv_pkg.sv */
package rv_pkg;

  // register width of the RV32I integer core
  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_imm    = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  // operation select for the ALU
  typedef enum logic [3:0] {
    alu_add       = 4'd0,
    alu_sub       = 4'd1,
    alu_sll       = 4'd2,
    alu_slt       = 4'd3,
    alu_sltu      = 4'd4,
    alu_xor       = 4'd5,
    alu_srl       = 4'd6,
    alu_sra       = 4'd7,
    alu_or        = 4'd8,
    alu_and       = 4'd9,
    alu_pass_b    = 4'd10,
    alu_pc_plus_b = 4'd11
  } alu_op_e;

  // control flow class of an instruction
  typedef enum logic [2:0] {
    br_none = 3'd0,
    br_cond = 3'd1,
    br_jal  = 3'd2,
    br_jalr = 3'd3
  } br_kind_e;

  typedef struct packed {
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    reg_idx_t   rd;
    // sign-extended immediate of the instruction format
    word_t      imm;
    logic       use_imm;
    alu_op_e    alu_op;
    br_kind_e   br_kind;
    logic [2:0] funct3;
    logic       writes_rd;
    logic       is_ecall;
    logic       illegal;
  } decoded_t;

  // one record per executed instruction
  typedef struct packed {
    word_t    pc;
    word_t    insn;
    reg_idx_t rd;
    logic     rd_we;
    word_t    rd_data;
    word_t    next_pc;
    logic     halted;
    logic     illegal;
  } retire_t;

endpackage

/* rv_decoder.sv */
module rv_decoder (
  input  rv_pkg::word_t    insn,
  output rv_pkg::decoded_t dec
);

  rv_pkg::opcode_e opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic            f7_zero;
  logic            f7_alt;
  rv_pkg::word_t   imm_i;
  rv_pkg::word_t   imm_u;
  rv_pkg::word_t   imm_b;
  rv_pkg::word_t   imm_j;

  assign opcode  = rv_pkg::opcode_e'(insn[6:0]);
  assign funct3  = insn[14:12];
  assign funct7  = insn[31:25];
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt  = (funct7 == 7'b0100000);

  // immediates, already sign-extended
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  always_comb begin
    dec         = '0;
    dec.rs1     = insn[19:15];
    dec.rs2     = insn[24:20];
    dec.rd      = insn[11:7];
    dec.funct3  = funct3;
    dec.alu_op  = rv_pkg::alu_add;
    dec.br_kind = rv_pkg::br_none;

    case (opcode)
      rv_pkg::opc_lui: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = rv_pkg::alu_pass_b;
        dec.writes_rd = 1'b1;
      end
      rv_pkg::opc_auipc: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = rv_pkg::alu_pc_plus_b;
        dec.writes_rd = 1'b1;
      end
      rv_pkg::opc_jal: begin
        dec.imm       = imm_j;
        dec.br_kind   = rv_pkg::br_jal;
        dec.writes_rd = 1'b1;
      end
      rv_pkg::opc_jalr: begin
        dec.imm       = imm_i;
        dec.br_kind   = rv_pkg::br_jalr;
        dec.writes_rd = 1'b1;
        dec.illegal   = (funct3 != 3'b000);
      end
      rv_pkg::opc_branch: begin
        dec.imm     = imm_b;
        dec.br_kind = rv_pkg::br_cond;
        // funct3 010 and 011 are not defined for branches
        dec.illegal = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      rv_pkg::opc_imm, rv_pkg::opc_op: begin
        dec.imm       = imm_i;
        dec.use_imm   = (opcode == rv_pkg::opc_imm);
        dec.writes_rd = 1'b1;
        case (funct3)
          3'b000: dec.alu_op = (!dec.use_imm && f7_alt) ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b001: dec.alu_op = rv_pkg::alu_sll;
          3'b010: dec.alu_op = rv_pkg::alu_slt;
          3'b011: dec.alu_op = rv_pkg::alu_sltu;
          3'b100: dec.alu_op = rv_pkg::alu_xor;
          3'b101: dec.alu_op = f7_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
          3'b110: dec.alu_op = rv_pkg::alu_or;
          default: dec.alu_op = rv_pkg::alu_and;
        endcase
        // funct7 only matters for shifts with an immediate, but for every reg-reg op
        if (dec.use_imm) begin
          dec.illegal = ((funct3 == 3'b001) && !f7_zero) ||
                        ((funct3 == 3'b101) && !(f7_zero || f7_alt));
        end else begin
          dec.illegal = !(f7_zero ||
                          (f7_alt && ((funct3 == 3'b000) || (funct3 == 3'b101))));
        end
      end
      rv_pkg::opc_system: begin
        // only ecall is supported, everything else traps as illegal
        dec.is_ecall = (insn[31:7] == 25'd0);
        dec.illegal  = !dec.is_ecall;
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase

    if (dec.illegal) begin
      dec.br_kind   = rv_pkg::br_none;
      dec.writes_rd = 1'b0;
    end
  end

endmodule

/* rv_regfile.sv */
module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);

  localparam int num_regs = 32;

  rv_pkg::word_t regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // x0 is hardwired to zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // no write path, including a write to rd = 0 from the commit stage, may reach x0
  x0_stays_zero: assert property (
    @(posedge clk) disable iff (rst) regs[0] == '0
  );

endmodule

/* rv_alu.sv */
module rv_alu (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    alu_result
);

  rv_pkg::word_t op_b;
  logic [4:0]    shamt;
  logic          lt_signed;
  logic          lt_unsigned;

  // second operand is the immediate for op-imm, lui and auipc
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  assign lt_signed   = $signed(rs1_data) < $signed(op_b);
  assign lt_unsigned = rs1_data < op_b;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add: begin
        alu_result = rs1_data + op_b;
      end
      rv_pkg::alu_sub: begin
        alu_result = rs1_data - op_b;
      end
      rv_pkg::alu_sll: begin
        alu_result = rs1_data << shamt;
      end
      rv_pkg::alu_slt: begin
        alu_result = {{(rv_pkg::xlen-1){1'b0}}, lt_signed};
      end
      rv_pkg::alu_sltu: begin
        alu_result = {{(rv_pkg::xlen-1){1'b0}}, lt_unsigned};
      end
      rv_pkg::alu_xor: alu_result = rs1_data ^ op_b;
      rv_pkg::alu_srl: alu_result = rs1_data >> shamt;
      rv_pkg::alu_sra: begin
        alu_result = $signed(rs1_data) >>> shamt;
      end
      rv_pkg::alu_or:  alu_result = rs1_data | op_b;
      rv_pkg::alu_and: alu_result = rs1_data & op_b;
      // lui value
      rv_pkg::alu_pass_b: alu_result = op_b;
      // auipc value
      rv_pkg::alu_pc_plus_b: alu_result = pc + op_b;
      default: alu_result = '0;
    endcase
  end

endmodule

/* rv_branch_unit.sv */
module rv_branch_unit (
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::word_t    next_pc,
  output rv_pkg::word_t    link
);

  logic          taken;
  rv_pkg::word_t seq_pc;
  rv_pkg::word_t rel_target;
  rv_pkg::word_t jalr_sum;

  assign seq_pc     = pc + 32'd4;
  assign rel_target = pc + dec.imm;
  assign jalr_sum   = rs1_data + dec.imm;
  assign link       = seq_pc;

  // branch condition from funct3
  always_comb begin
    case (dec.funct3)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  taken = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  taken = rs1_data < rs2_data;
      3'b111:  taken = rs1_data >= rs2_data;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.br_kind)
      rv_pkg::br_cond: next_pc = taken ? rel_target : seq_pc;
      rv_pkg::br_jal:  next_pc = rel_target;
      // jalr target always has bit 0 cleared
      rv_pkg::br_jalr: next_pc = {jalr_sum[31:1], 1'b0};
      default:         next_pc = seq_pc;
    endcase
  end

endmodule

/* rv_commit.sv */
module rv_commit #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::decoded_t dec,
  input  rv_pkg::word_t    insn,
  input  logic             insn_valid,
  output logic             insn_ready,
  input  rv_pkg::word_t    alu_result,
  input  rv_pkg::word_t    next_pc,
  input  rv_pkg::word_t    link,
  output logic             rd_we,
  output rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    pc,
  output rv_pkg::retire_t  retire,
  output logic             retire_valid,
  input  logic             retire_ready
);

  logic halted;
  logic accept;
  logic wr_en;
  logic is_jump;

  // stall while a record is stuck or once ecall has retired
  assign insn_ready = !halted && !(retire_valid && !retire_ready);
  assign accept     = insn_valid && insn_ready;

  assign is_jump = (dec.br_kind == rv_pkg::br_jal) || (dec.br_kind == rv_pkg::br_jalr);
  assign rd_data = is_jump ? link : alu_result;
  assign wr_en   = dec.writes_rd && !dec.illegal;
  assign rd_we   = accept && wr_en;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc           <= RESET_PC;
      halted       <= 1'b0;
      retire_valid <= 1'b0;
    end else if (accept) begin
      pc           <= next_pc;
      retire_valid <= 1'b1;
      if (dec.is_ecall) begin
        halted <= 1'b1;
      end
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
    end
  end

  // retire record, captured on the accepting edge
  always_ff @(posedge clk) begin
    if (accept) begin
      retire.pc      <= pc;
      retire.insn    <= insn;
      retire.rd      <= dec.rd;
      retire.rd_we   <= wr_en;
      retire.rd_data <= rd_data;
      retire.next_pc <= next_pc;
      retire.halted  <= dec.is_ecall;
      retire.illegal <= dec.illegal;
    end
  end

  retire_held: assert property (
    @(posedge clk) disable iff (rst)
    retire_valid && !retire_ready |=> retire_valid && $stable(retire)
  );

endmodule

/* rv_core.sv */
module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  rv_pkg::word_t   insn,
  input  logic            insn_valid,
  output logic            insn_ready,
  output rv_pkg::word_t   pc,
  output rv_pkg::retire_t retire,
  output logic            retire_valid,
  input  logic            retire_ready
);

  rv_pkg::decoded_t dec;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;
  rv_pkg::word_t    alu_result;
  rv_pkg::word_t    next_pc;
  rv_pkg::word_t    link;
  logic             rd_we;
  rv_pkg::word_t    rd_data;

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rd_we),
    .rd       (dec.rd),
    .rd_data  (rd_data)
  );

  // ALU and branch unit work side by side on the same decoded instruction
  rv_alu u_alu (
    .dec        (dec),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result)
  );

  rv_branch_unit u_branch_unit (
    .dec      (dec),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .next_pc  (next_pc),
    .link     (link)
  );

  rv_commit #(
    .RESET_PC (RESET_PC)
  ) u_commit (
    .clk          (clk),
    .rst          (rst),
    .dec          (dec),
    .insn         (insn),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .alu_result   (alu_result),
    .next_pc      (next_pc),
    .link         (link),
    .rd_we        (rd_we),
    .rd_data      (rd_data),
    .pc           (pc),
    .retire       (retire),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready)
  );

endmodule

/* tb_rv_core.sv */
module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam rv_pkg::word_t reset_pc = 32'h0000_1000;
  // upper bound on issued instructions, each takes two clock cycles
  localparam int n_insns = 130;
  localparam int watchdog_ns = n_insns * 40 * 4 + 4000;

  logic            clk;
  logic            rst;
  rv_pkg::word_t   insn;
  logic            insn_valid;
  logic            insn_ready;
  rv_pkg::word_t   pc;
  rv_pkg::retire_t retire;
  logic            retire_valid;
  logic            retire_ready;

  // reference model state
  rv_pkg::word_t model_regs [32];
  rv_pkg::word_t model_pc;
  rv_pkg::word_t prev_next_pc;
  logic          have_prev;

  int errors;
  int tests_run;
  int tests_failed;

  rv_core #(
    .RESET_PC (reset_pc)
  ) u_rv_core (
    .clk          (clk),
    .rst          (rst),
    .insn         (insn),
    .insn_valid   (insn_valid),
    .insn_ready   (insn_ready),
    .pc           (pc),
    .retire       (retire),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("Checks failed");
    $finish;
  end

  // instruction encoders
  function automatic rv_pkg::word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                          input rv_pkg::reg_idx_t rd,
                                          input rv_pkg::reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input rv_pkg::reg_idx_t rd,
                                          input rv_pkg::reg_idx_t rs1,
                                          input rv_pkg::reg_idx_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t enc_u(input logic [6:0] opc, input rv_pkg::reg_idx_t rd,
                                          input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input rv_pkg::reg_idx_t rs1,
                                          input rv_pkg::reg_idx_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::word_t enc_j(input rv_pkg::reg_idx_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // alt selects sub for funct3 000 and sra for funct3 101
  function automatic rv_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                            input rv_pkg::word_t a, input rv_pkg::word_t b);
    rv_pkg::word_t y;
    case (f3)
      3'b000: y = alt ? (a - b) : (a + b);
      3'b001: y = a << b[4:0];
      3'b010: y = {31'd0, $signed(a) < $signed(b)};
      3'b011: y = {31'd0, a < b};
      3'b100: y = a ^ b;
      3'b101: begin
        if (alt) begin
          y = $signed(a) >>> b[4:0];
        end else begin
          y = a >> b[4:0];
        end
      end
      3'b110: y = a | b;
      default: y = a & b;
    endcase
    return y;
  endfunction

  // expected retire record from the model state before the instruction
  function automatic rv_pkg::retire_t predict(input rv_pkg::word_t ins);
    rv_pkg::retire_t r;
    logic [2:0]      f3;
    logic [6:0]      f7;
    rv_pkg::word_t   a;
    rv_pkg::word_t   b;
    rv_pkg::word_t   imm_i;
    logic            taken;
    f3    = ins[14:12];
    f7    = ins[31:25];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    r         = '0;
    r.pc      = model_pc;
    r.insn    = ins;
    r.rd      = ins[11:7];
    r.next_pc = model_pc + 32'd4;
    case (ins[6:0])
      rv_pkg::opc_lui: begin
        r.rd_we   = 1'b1;
        r.rd_data = {ins[31:12], 12'h000};
      end
      rv_pkg::opc_auipc: begin
        r.rd_we   = 1'b1;
        r.rd_data = model_pc + {ins[31:12], 12'h000};
      end
      rv_pkg::opc_jal: begin
        r.rd_we   = 1'b1;
        r.rd_data = model_pc + 32'd4;
        r.next_pc = model_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      rv_pkg::opc_jalr: begin
        if (f3 != 3'b000) begin
          r.illegal = 1'b1;
        end else begin
          r.rd_we   = 1'b1;
          r.rd_data = model_pc + 32'd4;
          r.next_pc = (a + imm_i) & ~32'd1;
        end
      end
      rv_pkg::opc_branch: begin
        case (f3)
          3'b000: taken = (a == b);
          3'b001: taken = (a != b);
          3'b100: taken = $signed(a) < $signed(b);
          3'b101: taken = $signed(a) >= $signed(b);
          3'b110: taken = a < b;
          3'b111: taken = a >= b;
          default: begin
            taken     = 1'b0;
            r.illegal = 1'b1;
          end
        endcase
        if (taken) begin
          r.next_pc = model_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      rv_pkg::opc_imm: begin
        if ((f3 == 3'b001 && f7 != 7'h00) ||
            (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20)) begin
          r.illegal = 1'b1;
        end else begin
          r.rd_we   = 1'b1;
          r.rd_data = alu_ref(f3, (f3 == 3'b101) && f7[5], a, imm_i);
        end
      end
      rv_pkg::opc_op: begin
        if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
          r.rd_we   = 1'b1;
          r.rd_data = alu_ref(f3, f7[5], a, b);
        end else begin
          r.illegal = 1'b1;
        end
      end
      rv_pkg::opc_system: begin
        if (ins[31:7] == '0) begin
          r.halted = 1'b1;
        end else begin
          r.illegal = 1'b1;
        end
      end
      default: r.illegal = 1'b1;
    endcase
    return r;
  endfunction

  task automatic compare_word(input string name, input rv_pkg::word_t got,
                              input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_retire(input rv_pkg::retire_t got, input rv_pkg::retire_t exp);
    compare_word("retire.pc", got.pc, exp.pc);
    compare_word("retire.insn", got.insn, exp.insn);
    compare_word("retire.rd", rv_pkg::word_t'(got.rd), rv_pkg::word_t'(exp.rd));
    compare_word("retire.rd_we", rv_pkg::word_t'(got.rd_we), rv_pkg::word_t'(exp.rd_we));
    // rd_data only carries meaning when the record writes a register
    if (exp.rd_we) begin
      compare_word("retire.rd_data", got.rd_data, exp.rd_data);
    end
    compare_word("retire.next_pc", got.next_pc, exp.next_pc);
    compare_word("retire.halted", rv_pkg::word_t'(got.halted), rv_pkg::word_t'(exp.halted));
    compare_word("retire.illegal", rv_pkg::word_t'(got.illegal), rv_pkg::word_t'(exp.illegal));
  endtask

  task automatic expect_true(input logic cond, input string what);
    if (cond !== 1'b1) begin
      $display("%0t: %s", $time, what);
      errors++;
    end
  endtask

  // checks the record at hand and advances the model
  task automatic check_record(input rv_pkg::retire_t exp);
    expect_true(retire_valid, "retire_valid did not rise one cycle after acceptance");
    compare_retire(retire, exp);
    if (have_prev) begin
      compare_word("retire.pc", retire.pc, prev_next_pc);
    end
    prev_next_pc = retire.next_pc;
    have_prev    = 1'b1;
    if (exp.rd_we && exp.rd != '0) begin
      model_regs[exp.rd] = exp.rd_data;
    end
    model_pc = exp.next_pc;
  endtask

  task automatic issue(input rv_pkg::word_t ins);
    rv_pkg::retire_t exp;
    @(posedge clk);
    insn       <= ins;
    insn_valid <= 1'b1;
    @(negedge clk);
    while (!insn_ready) begin
      @(negedge clk);
    end
    compare_word("pc", pc, model_pc);
    exp = predict(ins);
    @(posedge clk);
    insn_valid <= 1'b0;
    @(negedge clk);
    check_record(exp);
  endtask

  // lui plus addi, the low part is sign-extended by addi
  task automatic load_reg(input rv_pkg::reg_idx_t rd, input rv_pkg::word_t v);
    rv_pkg::word_t hi;
    hi = (v + 32'h800) >> 12;
    issue(enc_u(rv_pkg::opc_lui, rd, hi[19:0]));
    issue(enc_i(rv_pkg::opc_imm, 3'b000, rd, rd, v[11:0]));
  endtask

  task automatic end_test(input string name, input int errs0);
    tests_run++;
    if (errors == errs0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs0);
    end
  endtask

  task automatic test_reset();
    int errs0;
    errs0 = errors;
    @(negedge clk);
    expect_true(insn_ready, "insn_ready is low after reset");
    expect_true(!retire_valid, "retire_valid is high after reset");
    compare_word("pc", pc, reset_pc);
    end_test("reset", errs0);
  endtask

  task automatic test_imm_ops();
    int            errs0;
    rv_pkg::word_t v1;
    rv_pkg::word_t v2;
    rv_pkg::word_t rnd;
    errs0 = errors;
    for (int k = 0; k < 2; k++) begin
      v1 = $urandom;
      // negative operand for srai
      v2 = $urandom | 32'h8000_0000;
      load_reg(1, v1);
      load_reg(2, v2);
      rnd = $urandom;
      issue(enc_u(rv_pkg::opc_lui, 3, rnd[31:12]));
      rnd = $urandom;
      issue(enc_u(rv_pkg::opc_auipc, 4, rnd[31:12]));
      // addi, slti, sltiu, xori, ori and andi
      for (int f = 0; f < 8; f++) begin
        if (f != 1 && f != 5) begin
          rnd = $urandom;
          issue(enc_i(rv_pkg::opc_imm, f[2:0], 16 + f, (f % 2) ? 2 : 1, rnd[11:0]));
        end
      end
      rnd = $urandom;
      issue(enc_i(rv_pkg::opc_imm, 3'b001, 24, 1, {7'h00, rnd[4:0]}));
      issue(enc_i(rv_pkg::opc_imm, 3'b101, 25, 2, {7'h00, rnd[9:5]}));
      issue(enc_i(rv_pkg::opc_imm, 3'b101, 26, 2, {7'h20, rnd[14:10]}));
      // read back earlier results
      issue(enc_i(rv_pkg::opc_imm, 3'b000, 27, 16, 12'd0));
      issue(enc_i(rv_pkg::opc_imm, 3'b000, 28, 26, 12'd0));
    end
    end_test("imm_ops", errs0);
  endtask

  task automatic test_reg_ops();
    int                errs0;
    rv_pkg::word_t     rnd;
    rv_pkg::reg_idx_t  s1;
    rv_pkg::reg_idx_t  s2;
    errs0 = errors;
    rnd   = $urandom;
    load_reg(5, 32'h8000_0000);
    load_reg(6, 32'h7fff_ffff);
    load_reg(7, 32'hffff_ffff);
    load_reg(8, rnd);
    for (int p = 0; p < 4; p++) begin
      case (p)
        0: begin
          s1 = 5;
          s2 = 6;
        end
        1: begin
          s1 = 6;
          s2 = 5;
        end
        2: begin
          s1 = 7;
          s2 = 8;
        end
        default: begin
          s1 = 8;
          s2 = 5;
        end
      endcase
      for (int f = 0; f < 8; f++) begin
        for (int alt = 0; alt < 2; alt++) begin
          if (alt == 0 || f == 0 || f == 5) begin
            issue(enc_r(alt ? 7'h20 : 7'h00, f[2:0], 10 + p, s1, s2));
          end
        end
      end
    end
    // write to x0, then read it back
    issue(enc_r(7'h00, 3'b000, 0, 5, 6));
    issue(enc_r(7'h00, 3'b000, 12, 0, 0));
    compare_word("retire.rd_data", retire.rd_data, '0);
    end_test("reg_ops", errs0);
  endtask

  task automatic test_branches();
    int               errs0;
    rv_pkg::reg_idx_t s1;
    rv_pkg::reg_idx_t s2;
    logic [12:0]      off;
    errs0 = errors;
    for (int f = 0; f < 8; f++) begin
      if (f != 2 && f != 3) begin
        // operand pairs give each condition a taken and a not-taken case
        for (int p = 0; p < 3; p++) begin
          s1  = (p == 1) ? 6 : 5;
          s2  = (p == 0) ? 6 : 5;
          off = p[0] ? 13'h1ff8 : 13'd24;
          issue(enc_b(f[2:0], s1, s2, off));
        end
      end
    end
    end_test("branches", errs0);
  endtask

  task automatic test_jumps();
    int errs0;
    errs0 = errors;
    issue(enc_j(1, 21'd20));
    issue(enc_j(2, 21'h1f_fff4));
    issue(enc_i(rv_pkg::opc_jalr, 3'b000, 3, 1, 12'd5));
    expect_true(!retire.next_pc[0], "jalr target has bit 0 set");
    issue(enc_i(rv_pkg::opc_jalr, 3'b000, 4, 2, 12'hffd));
    expect_true(!retire.next_pc[0], "jalr target has bit 0 set");
    issue(enc_i(rv_pkg::opc_imm, 3'b000, 13, 3, 12'd0));
    end_test("jumps", errs0);
  endtask

  task automatic test_backpressure();
    int              errs0;
    rv_pkg::retire_t exp;
    rv_pkg::retire_t held;
    rv_pkg::word_t   bump;
    errs0 = errors;
    bump  = enc_i(rv_pkg::opc_imm, 3'b000, 12, 12, 12'd1);
    @(posedge clk);
    retire_ready <= 1'b0;
    insn         <= bump;
    insn_valid   <= 1'b1;
    @(negedge clk);
    expect_true(insn_ready, "insn_ready is low before the stall");
    exp = predict(bump);
    // the same increment stays offered while the record is stuck
    @(posedge clk);
    @(negedge clk);
    check_record(exp);
    held = retire;
    repeat (6) begin
      @(negedge clk);
      expect_true(!insn_ready, "insn_ready is high while the retire record is stalled");
      expect_true(retire_valid, "retire_valid dropped while retire_ready is low");
      compare_retire(retire, held);
      compare_word("pc", pc, model_pc);
    end
    @(posedge clk);
    retire_ready <= 1'b1;
    @(negedge clk);
    expect_true(insn_ready, "insn_ready stayed low after retire_ready rose");
    exp = predict(bump);
    @(posedge clk);
    insn_valid <= 1'b0;
    @(negedge clk);
    check_record(exp);
    // x12 must hold exactly two increments
    issue(enc_i(rv_pkg::opc_imm, 3'b000, 13, 12, 12'd0));
    end_test("backpressure", errs0);
  endtask

  task automatic test_illegal_halt();
    int errs0;
    errs0 = errors;
    issue(32'hffff_ffff);
    // mul is outside RV32I
    issue(enc_r(7'h01, 3'b000, 5, 6, 7));
    expect_true(retire.illegal && !retire.rd_we, "mul did not retire as illegal");
    issue(32'h0010_0073);
    issue(enc_i(rv_pkg::opc_jalr, 3'b001, 6, 1, 12'd0));
    issue(enc_r(7'h00, 3'b000, 14, 5, 6));
    issue(32'h0000_0073);
    expect_true(retire.halted, "ecall record does not have halted set");
    @(posedge clk);
    insn       <= enc_i(rv_pkg::opc_imm, 3'b000, 15, 0, 12'd1);
    insn_valid <= 1'b1;
    repeat (6) begin
      @(negedge clk);
      expect_true(!insn_ready, "insn_ready is high after the core halted");
    end
    expect_true(!retire_valid, "retire_valid is still high after the halt record left");
    compare_word("pc", pc, model_pc);
    @(posedge clk);
    insn_valid <= 1'b0;
    end_test("illegal_halt", errs0);
  endtask

  initial begin
    void'($urandom(32'hdaec299c));
    rst          = 1'b1;
    insn         = '0;
    insn_valid   = 1'b0;
    retire_ready = 1'b1;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_pc  = reset_pc;
    have_prev = 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_imm_ops();
    test_reg_ops();
    test_branches();
    test_jumps();
    test_backpressure();
    test_illegal_halt();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* rv_core.f */
rv_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_branch_unit.sv
rv_commit.sv
rv_core.sv
tb_rv_core.sv
